// ==== common/axi2axil_pkg.sv ====
// AXI to AXI-lite read converter shared definitions
// Bus widths, burst and response codes, channel payloads

package axi2axil_pkg;

	localparam int ID_W   = 2;
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// AXI burst type
	typedef logic [1:0] burst_t;
	localparam burst_t BURST_FIXED = 2'b00;
	localparam burst_t BURST_INCR  = 2'b01;
	localparam burst_t BURST_WRAP  = 2'b10;

	// Read response
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// AXI AR channel, len is beats minus one
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		burst_t            burst;
	} ar_req_t;

	// AXI-lite R channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		resp_t             resp;
	} lite_rbeat_t;

	// AXI R channel
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		resp_t             resp;
		logic              last;
	} axi_rbeat_t;

	// One outstanding burst
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [7:0]      len;
	} burst_tag_t;

endpackage

// ==== verilog/skid_buffer.sv ====
// Skid buffer with registered input ready
// Passes data straight through when empty, holds one entry on a stall

`timescale 1ns/1ps

module skid_buffer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	logic     r_valid;
	logic     r_valid_next;
	payload_t r_data;

	always_comb
	begin
		r_valid_next = r_valid;
		if (r_valid && i_ready)
			r_valid_next = 1'b0;
		else if (!r_valid && i_valid && o_ready && !i_ready)
			r_valid_next = 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_valid <= 1'b0;
			o_ready <= 1'b0;
		end
		else
		begin
			r_valid <= r_valid_next;
			o_ready <= !r_valid_next;
		end
	end

	// Ready high means the skid register is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	assign o_valid = r_valid || (i_valid && o_ready);
	assign o_data  = r_valid ? r_data : i_data;

	a_hold_until_taken: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_valid && !i_ready) |=> (o_valid && o_data == $past(o_data)));

endmodule

// ==== verilog/burst_addr_step.sv ====
// Next beat address for AXI bursts
// FIXED holds, INCR steps by the beat size, WRAP steps within an aligned window

`timescale 1ns/1ps

module burst_addr_step (
	input  logic [axi2axil_pkg::ADDR_W-1:0] i_addr,
	input  logic [2:0]                      i_size,
	input  axi2axil_pkg::burst_t            i_burst,
	input  logic [7:0]                      i_len,
	output logic [axi2axil_pkg::ADDR_W-1:0] o_next_addr
);

	localparam int AW    = axi2axil_pkg::ADDR_W;
	// Wide enough for 256 beats of 128 bytes
	localparam int WIN_W = AW + 8;

	logic [AW-1:0]    incr;
	logic [WIN_W-1:0] window;
	logic [AW-1:0]    wrap_mask;
	logic [AW-1:0]    stepped;

	// Bytes per beat
	assign incr    = AW'(1) << i_size;
	assign stepped = i_addr + incr;

	// Window of (len+1) beats; a window past the address space wraps to all ones
	assign window    = (WIN_W'(i_len) + WIN_W'(1)) << i_size;
	assign wrap_mask = window[AW-1:0] - AW'(1);

	always_comb
	begin
		case (i_burst)
		axi2axil_pkg::BURST_INCR:
			o_next_addr = stepped;
		axi2axil_pkg::BURST_WRAP:
			o_next_addr = (i_addr & ~wrap_mask) | (stepped & wrap_mask);
		default:
			o_next_addr = i_addr;
		endcase
	end

endmodule

// ==== verilog/burst_splitter.sv ====
// AXI read burst splitter
// Holds one accepted burst and issues one AXI-lite read address per beat,
// logging the burst ID and length in the tag FIFO

`timescale 1ns/1ps

module burst_splitter (
	input  logic                            S_AXI_ACLK,
	input  logic                            S_AXI_ARESETN,
	input  axi2axil_pkg::ar_req_t           i_req,
	input  logic                            i_req_valid,
	output logic                            o_req_ready,
	input  logic                            i_tag_full,
	output logic                            o_tag_push,
	output axi2axil_pkg::burst_tag_t        o_tag,
	output logic [axi2axil_pkg::ADDR_W-1:0] o_m_araddr,
	output logic                            o_m_arvalid,
	input  logic                            i_m_arready
);

	logic                            accept;
	logic                            issue;
	logic [7:0]                      r_remain;
	logic [axi2axil_pkg::ADDR_W-1:0] r_addr;
	logic [2:0]                      r_size;
	axi2axil_pkg::burst_t            r_burst;
	logic [7:0]                      r_len;
	logic [axi2axil_pkg::ADDR_W-1:0] next_addr;

	assign issue       = o_m_arvalid && i_m_arready;
	// Free when idle or on the final beat's handshake
	assign o_req_ready = (!o_m_arvalid || (i_m_arready && r_remain == 8'd0)) && !i_tag_full;
	assign accept      = i_req_valid && o_req_ready;

	assign o_tag_push = accept;
	assign o_tag      = '{id: i_req.id, len: i_req.len};
	assign o_m_araddr = r_addr;

	////////////////////
	// Beat control
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_m_arvalid <= 1'b0;
			r_remain    <= 8'd0;
		end
		else if (accept)
		begin
			o_m_arvalid <= 1'b1;
			r_remain    <= i_req.len;
		end
		else if (issue)
		begin
			if (r_remain == 8'd0)
				o_m_arvalid <= 1'b0;
			else
				r_remain <= r_remain - 8'd1;
		end
	end

	// Burst parameters and current address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			r_addr  <= i_req.addr;
			r_size  <= i_req.size;
			r_burst <= i_req.burst;
			r_len   <= i_req.len;
		end
		else if (issue)
			r_addr <= next_addr;
	end

	burst_addr_step u_burst_addr_step (
		.i_addr      (r_addr),
		.i_size      (r_size),
		.i_burst     (r_burst),
		.i_len       (r_len),
		.o_next_addr (next_addr)
	);

	// Address and valid hold until the AXI-lite slave takes them
	a_ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_m_arvalid && !i_m_arready) |=> (o_m_arvalid && $stable(o_m_araddr)));

endmodule

// ==== verilog/burst_tag_fifo.sv ====
// Tag FIFO of outstanding read bursts
// Circular buffer with an extra pointer bit to tell full from empty

`timescale 1ns/1ps

module burst_tag_fifo #(
	parameter int LGFIFO = 2
) (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  logic                     i_push,
	input  axi2axil_pkg::burst_tag_t i_tag,
	output logic                     o_full,
	input  logic                     i_pop,
	output axi2axil_pkg::burst_tag_t o_head,
	output logic                     o_empty
);

	axi2axil_pkg::burst_tag_t mem [2**LGFIFO];
	logic [LGFIFO:0]          wr_ptr;
	logic [LGFIFO:0]          rd_ptr;
	logic                     do_push;
	logic                     do_pop;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[LGFIFO] != rd_ptr[LGFIFO])
		&& (wr_ptr[LGFIFO-1:0] == rd_ptr[LGFIFO-1:0]);

	// A pop frees the slot for a push in the same cycle
	assign do_push = i_push && (!o_full || i_pop);
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_push)
			mem[wr_ptr[LGFIFO-1:0]] <= i_tag;
	end

	assign o_head = mem[rd_ptr[LGFIFO-1:0]];

	a_no_pop_empty: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_pop |-> !o_empty);

endmodule

// ==== verilog/read_response_merger.sv ====
// AXI read response merger
// Tags each AXI-lite response with the burst ID, marks RLAST,
// and registers the AXI R channel

`timescale 1ns/1ps

module read_response_merger (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  axi2axil_pkg::lite_rbeat_t i_beat,
	input  logic                     i_beat_valid,
	output logic                     o_beat_ready,
	input  axi2axil_pkg::burst_tag_t i_head,
	input  logic                     i_tag_empty,
	output logic                     o_tag_pop,
	output axi2axil_pkg::axi_rbeat_t o_r,
	output logic                     o_r_valid,
	input  logic                     i_r_ready
);

	logic       accept;
	logic       last;
	logic [7:0] r_count;

	// Output register is free or draining this cycle
	assign o_beat_ready = !o_r_valid || i_r_ready;
	assign accept       = i_beat_valid && o_beat_ready;

	// Beats seen so far in the head burst
	assign last      = (r_count == i_head.len);
	assign o_tag_pop = accept && last;

	////////////////////
	// Control
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_r_valid <= 1'b0;
			r_count   <= 8'd0;
		end
		else
		begin
			if (accept)
				o_r_valid <= 1'b1;
			else if (i_r_ready)
				o_r_valid <= 1'b0;

			if (accept)
			begin
				if (last)
					r_count <= 8'd0;
				else
					r_count <= r_count + 8'd1;
			end
		end
	end

	////////////////////
	// R payload
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
			o_r <= '{id: i_head.id, data: i_beat.data, resp: i_beat.resp, last: last};
	end

	// A response never arrives ahead of its burst's tag
	a_tag_present: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		accept |-> !i_tag_empty);

endmodule

// ==== verilog/axi2axil_rd.sv ====
// AXI to AXI-lite read converter
// AR skid, burst splitter, tag FIFO, R skid and response merger in a chain

`timescale 1ns/1ps

module axi2axil_rd #(
	parameter int LGFIFO = 2
) (
	input  logic                            S_AXI_ACLK,
	input  logic                            S_AXI_ARESETN,
	// AXI slave side
	input  axi2axil_pkg::ar_req_t           i_s_ar,
	input  logic                            i_s_arvalid,
	output logic                            o_s_arready,
	output axi2axil_pkg::axi_rbeat_t        o_s_r,
	output logic                            o_s_rvalid,
	input  logic                            i_s_rready,
	// AXI-lite master side
	output logic [axi2axil_pkg::ADDR_W-1:0] o_m_araddr,
	output logic                            o_m_arvalid,
	input  logic                            i_m_arready,
	input  axi2axil_pkg::lite_rbeat_t       i_m_r,
	input  logic                            i_m_rvalid,
	output logic                            o_m_rready
);

	axi2axil_pkg::ar_req_t     ar_req;
	logic                      ar_valid;
	logic                      ar_ready;
	axi2axil_pkg::burst_tag_t  tag_in;
	axi2axil_pkg::burst_tag_t  tag_head;
	logic                      tag_push;
	logic                      tag_pop;
	logic                      tag_full;
	logic                      tag_empty;
	axi2axil_pkg::lite_rbeat_t r_beat;
	logic                      r_valid;
	logic                      r_ready;

	////////////////////
	// Request path
	skid_buffer #(.payload_t(axi2axil_pkg::ar_req_t)) u_ar_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_s_arvalid),
		.o_ready       (o_s_arready),
		.i_data        (i_s_ar),
		.o_valid       (ar_valid),
		.i_ready       (ar_ready),
		.o_data        (ar_req)
	);

	burst_splitter u_burst_splitter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_req         (ar_req),
		.i_req_valid   (ar_valid),
		.o_req_ready   (ar_ready),
		.i_tag_full    (tag_full),
		.o_tag_push    (tag_push),
		.o_tag         (tag_in),
		.o_m_araddr    (o_m_araddr),
		.o_m_arvalid   (o_m_arvalid),
		.i_m_arready   (i_m_arready)
	);

	burst_tag_fifo #(.LGFIFO(LGFIFO)) u_burst_tag_fifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (tag_push),
		.i_tag         (tag_in),
		.o_full        (tag_full),
		.i_pop         (tag_pop),
		.o_head        (tag_head),
		.o_empty       (tag_empty)
	);

	////////////////////
	// Response path
	skid_buffer #(.payload_t(axi2axil_pkg::lite_rbeat_t)) u_r_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_m_rvalid),
		.o_ready       (o_m_rready),
		.i_data        (i_m_r),
		.o_valid       (r_valid),
		.i_ready       (r_ready),
		.o_data        (r_beat)
	);

	read_response_merger u_read_response_merger (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_beat        (r_beat),
		.i_beat_valid  (r_valid),
		.o_beat_ready  (r_ready),
		.i_head        (tag_head),
		.i_tag_empty   (tag_empty),
		.o_tag_pop     (tag_pop),
		.o_r           (o_s_r),
		.o_r_valid     (o_s_rvalid),
		.i_r_ready     (i_s_rready)
	);

endmodule

// ==== verif/tb_axi2axil_rd.sv ====
// Testbench for the AXI to AXI-lite read converter
// Bursts from a table, an AXI-lite memory model, beat by beat checks

`timescale 1ns/1ps

module tb_axi2axil_rd;

	localparam int NUM_CASES  = 8;
	localparam int RST_CYCLES = 16;

	typedef struct packed {
		logic [1:0]           id;
		logic [7:0]           addr;
		logic [7:0]           len;
		logic [2:0]           size;
		axi2axil_pkg::burst_t burst;
		logic                 overlap;   // next burst follows without waiting
		logic                 rnd_ready;
	} burst_case_t;

	typedef struct packed {
		logic [7:0] test;
		logic [1:0] id;
		logic [7:0] addr;
		logic       last;
	} exp_beat_t;

	logic                      S_AXI_ACLK;
	logic                      S_AXI_ARESETN;
	axi2axil_pkg::ar_req_t     i_s_ar;
	logic                      i_s_arvalid;
	logic                      o_s_arready;
	axi2axil_pkg::axi_rbeat_t  o_s_r;
	logic                      o_s_rvalid;
	logic                      i_s_rready;
	logic [7:0]                o_m_araddr;
	logic                      o_m_arvalid;
	logic                      i_m_arready;
	axi2axil_pkg::lite_rbeat_t i_m_r;
	logic                      i_m_rvalid;
	logic                      o_m_rready;

	burst_case_t cases [NUM_CASES];
	exp_beat_t   exp_q [$];
	logic [7:0]  addr_q [$];
	int unsigned due_q [$];
	integer      seed = 32'h6af8;
	logic        rready_random;
	int          errors;
	int          checks;
	int          err_base;
	int          tests_done;
	int          beat_cnt;

	axi2axil_rd #(.LGFIFO(2)) u_axi2axil_rd (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_s_ar        (i_s_ar),
		.i_s_arvalid   (i_s_arvalid),
		.o_s_arready   (o_s_arready),
		.o_s_r         (o_s_r),
		.o_s_rvalid    (o_s_rvalid),
		.i_s_rready    (i_s_rready),
		.o_m_araddr    (o_m_araddr),
		.o_m_arvalid   (o_m_arvalid),
		.i_m_arready   (i_m_arready),
		.i_m_r         (i_m_r),
		.i_m_rvalid    (i_m_rvalid),
		.o_m_rready    (o_m_rready)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////
	// Burst table
	task automatic load_table();
		cases[0] = '{2'd1, 8'h04, 8'd0, 3'd2, axi2axil_pkg::BURST_INCR, 1'b0, 1'b0};
		cases[1] = '{2'd2, 8'h20, 8'd7, 3'd2, axi2axil_pkg::BURST_INCR, 1'b0, 1'b0};
		// Starts mid window, wraps to 0x10
		cases[2] = '{2'd3, 8'h18, 8'd3, 3'd2, axi2axil_pkg::BURST_WRAP, 1'b0, 1'b0};
		cases[3] = '{2'd0, 8'h40, 8'd3, 3'd2, axi2axil_pkg::BURST_FIXED, 1'b0, 1'b0};
		cases[4] = '{2'd1, 8'h84, 8'd2, 3'd2, axi2axil_pkg::BURST_INCR, 1'b0, 1'b0};
		// Back to back group under random R back-pressure
		cases[5] = '{2'd1, 8'h30, 8'd3, 3'd2, axi2axil_pkg::BURST_INCR, 1'b1, 1'b1};
		cases[6] = '{2'd2, 8'h94, 8'd1, 3'd2, axi2axil_pkg::BURST_WRAP, 1'b1, 1'b1};
		cases[7] = '{2'd3, 8'h08, 8'd5, 3'd1, axi2axil_pkg::BURST_INCR, 1'b0, 1'b1};
	endtask

	// Address of beat k by the AXI burst rules
	function automatic logic [7:0] expected_addr(burst_case_t c, int k);
		int bytes;
		int wsize;
		int base;
		bytes = 1 << c.size;
		wsize = (c.len + 1) * bytes;
		base  = (c.addr / wsize) * wsize;
		case (c.burst)
		axi2axil_pkg::BURST_FIXED:
			return c.addr;
		axi2axil_pkg::BURST_INCR:
			return 8'(c.addr + k * bytes);
		default:
			return 8'(base + (c.addr - base + k * bytes) % wsize);
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want)
		begin
			$display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
			errors++;
		end
	endtask

	// Called at the falling edge before an R handshake
	task automatic score_beat();
		exp_beat_t e;
		if (exp_q.size() == 0)
		begin
			$display("Unexpected R beat with ID %0d while no burst is outstanding", o_s_r.id);
			errors++;
		end
		else
		begin
			e = exp_q.pop_front();
			beat_cnt++;
			compare_value("RID", o_s_r.id, e.id);
			compare_value("RDATA", o_s_r.data, {4{e.addr}});
			compare_value("RRESP", o_s_r.resp,
				e.addr[7] ? axi2axil_pkg::RESP_SLVERR : axi2axil_pkg::RESP_OKAY);
			compare_value("RLAST", o_s_r.last, e.last);
			if (e.last)
			begin
				$display("Test %0d done: ID %0d, %0d beats, %0d errors",
					e.test, e.id, beat_cnt, errors - err_base);
				err_base = errors;
				beat_cnt = 0;
				tests_done++;
			end
		end
	endtask

	// Caller sits at a falling edge
	task automatic issue_burst(input int idx);
		burst_case_t c;
		exp_beat_t   e;
		int          k;
		c = cases[idx];
		for (k = 0; k <= c.len; k++)
		begin
			e.test = idx[7:0];
			e.id   = c.id;
			e.addr = expected_addr(c, k);
			e.last = (k == c.len);
			exp_q.push_back(e);
		end
		i_s_ar      = '{id: c.id, addr: c.addr, len: c.len, size: c.size, burst: c.burst};
		i_s_arvalid = 1'b1;
		while (!o_s_arready)
			@(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		i_s_arvalid = 1'b0;
	endtask

	////////////////////
	// AXI-lite memory model and R sink
	initial
	begin : axil_memory
		logic [7:0]  a;
		int unsigned cycle;
		logic        beat_hs;
		integer      rnd;
		cycle       = 0;
		beat_hs     = 1'b0;
		i_m_arready = 1'b1;
		i_m_rvalid  = 1'b0;
		i_m_r       = '0;
		i_s_rready  = 1'b0;
		forever
		begin
			@(negedge S_AXI_ACLK);
			rnd = $random(seed);
			i_s_rready = rready_random ? rnd[0] : 1'b1;
			if (beat_hs)
				i_m_rvalid = 1'b0;
			if (!i_m_rvalid && addr_q.size() != 0 && due_q[0] <= cycle)
			begin
				a = addr_q.pop_front();
				void'(due_q.pop_front());
				i_m_r.data = {4{a}};
				i_m_r.resp = a[7] ? axi2axil_pkg::RESP_SLVERR : axi2axil_pkg::RESP_OKAY;
				i_m_rvalid = 1'b1;
			end
			beat_hs = i_m_rvalid && o_m_rready;
			// Address taken at the next rising edge, answered 0 to 3 cycles on
			if (o_m_arvalid && i_m_arready)
			begin
				rnd = $random(seed);
				addr_q.push_back(o_m_araddr);
				due_q.push_back(cycle + 1 + $unsigned(rnd) % 4);
			end
			if (o_s_rvalid && i_s_rready)
				score_beat();
			cycle++;
		end
	end

	initial
	begin : watchdog
		repeat (RST_CYCLES + 200 * NUM_CASES)
			@(posedge S_AXI_ACLK);
		$display("Timeout: %0d beats still missing", exp_q.size());
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin : main
		int i;
		S_AXI_ARESETN = 1'b0;
		i_s_ar        = '0;
		i_s_arvalid   = 1'b0;
		rready_random = 1'b0;
		errors        = 0;
		checks        = 0;
		err_base      = 0;
		tests_done    = 0;
		beat_cnt      = 0;
		load_table();
		repeat (RST_CYCLES)
			@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		for (i = 0; i < NUM_CASES; i++)
		begin
			rready_random = cases[i].rnd_ready;
			issue_burst(i);
			if (!cases[i].overlap)
				while (exp_q.size() != 0)
					@(negedge S_AXI_ACLK);
		end
		rready_random = 1'b0;
		// Idle time to catch stray beats
		repeat (20)
			@(negedge S_AXI_ACLK);
		$display("%0d of %0d tests done, %0d checks, %0d errors",
			tests_done, NUM_CASES, checks, errors);
		if (errors == 0 && tests_done == NUM_CASES)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
common/axi2axil_pkg.sv
verilog/skid_buffer.sv
verilog/burst_addr_step.sv
verilog/burst_splitter.sv
verilog/burst_tag_fifo.sv
verilog/read_response_merger.sv
verilog/axi2axil_rd.sv
verif/tb_axi2axil_rd.sv
